// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int reg_count = 32;
    localparam int reg_aw    = 5;

    // instruction field positions
    localparam int opc_lo   = 0;
    localparam int opc_hi   = 2;
    localparam int funct_lo = 3;
    localparam int funct_hi = 5;
    localparam int rs1_lo   = 27;
    localparam int rs1_hi   = 31;
    localparam int rs2_lo   = 6;
    localparam int rs2_hi   = 10;
    localparam int rd_lo    = 22;
    localparam int rd_hi    = 26;
    localparam int imm_i_lo = 6;   // loads, imm alu, link jumps
    localparam int imm_i_hi = 21;
    localparam int imm_s_lo = 11;  // stores and branches
    localparam int imm_s_hi = 26;
    localparam int jt_lo    = 6;   // absolute jump target, word address
    localparam int jt_hi    = 31;

    typedef enum logic [2:0] {
        op_reg    = 3'd0,
        op_imm    = 3'd1,
        op_load   = 3'd2,
        op_store  = 3'd3,
        op_branch = 3'd4,
        op_jump   = 3'd5
    } opcode_e;

    // funct field of op_reg and op_imm
    typedef enum logic [2:0] {
        f_add, f_sub, f_and, f_or, f_xor, f_sll, f_srl, f_slt
    } alu_funct_e;

    // funct field of op_branch
    typedef enum logic [2:0] {
        b_eq, b_ne, b_lt, b_ge, b_ltu, b_geu
    } br_funct_e;

    typedef enum logic [2:0] {
        j_abs  = 3'd0,
        j_link = 3'd1,
        j_reg  = 3'd2
    } jump_e;

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // operation carried in the decode register
    typedef enum logic [3:0] {
        add,
        sub,
        and_,
        or_,
        xor_,
        sll,
        srl,
        slt,
        pass_b   // link jumps, result is op2
    } alu_op_e;

    typedef enum logic [2:0] {
        eq,
        ne,
        lt,
        ge,
        ltu,
        geu
    } br_cond_e;

endpackage

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [isa_pkg::reg_aw-1:0] rs1_addr,
    input  logic [isa_pkg::reg_aw-1:0] rs2_addr,
    output logic [31:0]               rs1_data,
    output logic [31:0]               rs2_data,
    input  logic                      we,
    input  logic [isa_pkg::reg_aw-1:0] wr_addr,
    input  logic [31:0]               wr_data
);

    logic [31:0] regs [isa_pkg::reg_count];

    // flop array, all registers start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 is reset to zero and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int pc_width = 27
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [31:0]                inst,
    input  logic [pc_width-1:0]        pc,
    input  logic                       advance,
    input  logic                       flush,
    input  logic [31:0]                alu_fwd,
    input  logic [isa_pkg::reg_aw-1:0] ex_rd,
    input  logic                       ex_fwd_ok,
    input  logic                       wb_valid,
    input  logic [isa_pkg::reg_aw-1:0] wb_rd,
    input  logic [31:0]                wb_data,
    output logic                       hold_n,
    output logic [31:0]                dec_op1,
    output logic [31:0]                dec_op2,
    output pipe_pkg::alu_op_e          dec_alu_op,
    output pipe_pkg::br_cond_e         dec_br_cond,
    output logic                       dec_branch,
    output logic                       dec_jump,
    output logic [isa_pkg::reg_aw-1:0] dec_rd,
    output logic                       dec_rd_valid,
    output logic                       dec_mem_re,
    output logic                       dec_mem_we,
    output logic [31:0]                dec_store_data,
    output logic [31:0]                dec_daddr,
    output logic [pc_width-1:0]        dec_npc
);

    isa_pkg::opcode_e           op;
    logic [2:0]                 funct;
    logic [isa_pkg::reg_aw-1:0] rs1, rs2, rd;
    logic [31:0]                imm_i, imm_s;
    logic [31:0]                rf_rs1, rf_rs2;
    logic [31:0]                rs1_val, rs2_val;
    logic                       uses_rs1, uses_rs2, is_link;
    logic [31:0]                pc_ext, link_addr;
    logic [31:0]                br_tgt, ja_tgt, jl_tgt, jr_tgt, n_tgt;
    logic [31:0]                n_op1, n_op2, n_daddr;
    pipe_pkg::alu_op_e          n_alu_op;
    pipe_pkg::br_cond_e         n_br_cond;
    logic                       n_branch, n_jump, n_rd_valid;
    logic                       lw_hazard, run, bubble;

    assign op    = isa_pkg::opcode_e'(inst[isa_pkg::opc_hi:isa_pkg::opc_lo]);
    assign funct = inst[isa_pkg::funct_hi:isa_pkg::funct_lo];
    assign rs1   = inst[isa_pkg::rs1_hi:isa_pkg::rs1_lo];
    assign rs2   = inst[isa_pkg::rs2_hi:isa_pkg::rs2_lo];
    assign rd    = inst[isa_pkg::rd_hi:isa_pkg::rd_lo];
    assign imm_i = 32'($signed(inst[isa_pkg::imm_i_hi:isa_pkg::imm_i_lo]));
    assign imm_s = 32'($signed(inst[isa_pkg::imm_s_hi:isa_pkg::imm_s_lo]));

    assign is_link  = op == isa_pkg::op_jump &&
                      (funct == isa_pkg::j_link || funct == isa_pkg::j_reg);
    assign uses_rs1 = op inside {isa_pkg::op_reg, isa_pkg::op_imm, isa_pkg::op_load,
                                 isa_pkg::op_store, isa_pkg::op_branch} ||
                      (op == isa_pkg::op_jump && funct == isa_pkg::j_reg);
    assign uses_rs2 = op inside {isa_pkg::op_reg, isa_pkg::op_store, isa_pkg::op_branch};

    reg_file rf_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .we       (wb_valid & advance),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    // ex_fwd_ok and wb_valid imply rd != 0, so r0 is never forwarded
    assign rs1_val = (ex_fwd_ok && ex_rd == rs1) ? alu_fwd :
                     (wb_valid && wb_rd == rs1)  ? wb_data : rf_rs1;
    assign rs2_val = (ex_fwd_ok && ex_rd == rs2) ? alu_fwd :
                     (wb_valid && wb_rd == rs2)  ? wb_data : rf_rs2;

    assign pc_ext    = 32'(pc);
    assign link_addr = pc_ext + 32'd4;
    assign br_tgt    = pc_ext + (imm_s << 2);
    assign ja_tgt    = 32'({inst[isa_pkg::jt_hi:isa_pkg::jt_lo], 2'b00});
    assign jl_tgt    = pc_ext + (imm_i << 2);
    assign jr_tgt    = rs1_val + (imm_i << 2);
    assign n_daddr   = rs1_val + ((op == isa_pkg::op_store) ? imm_s : imm_i);

    always_comb begin
        n_tgt = br_tgt;
        if (op == isa_pkg::op_jump) begin
            case (funct)
                isa_pkg::j_abs:  n_tgt = ja_tgt;
                isa_pkg::j_link: n_tgt = jl_tgt;
                default:         n_tgt = jr_tgt;
            endcase
        end
    end

    always_comb begin
        n_alu_op = pipe_pkg::add;   // loads and stores use daddr, not the alu
        case (op)
            isa_pkg::op_reg, isa_pkg::op_imm: begin
                case (isa_pkg::alu_funct_e'(funct))
                    isa_pkg::f_add: n_alu_op = pipe_pkg::add;
                    isa_pkg::f_sub: n_alu_op = pipe_pkg::sub;
                    isa_pkg::f_and: n_alu_op = pipe_pkg::and_;
                    isa_pkg::f_or:  n_alu_op = pipe_pkg::or_;
                    isa_pkg::f_xor: n_alu_op = pipe_pkg::xor_;
                    isa_pkg::f_sll: n_alu_op = pipe_pkg::sll;
                    isa_pkg::f_srl: n_alu_op = pipe_pkg::srl;
                    default:        n_alu_op = pipe_pkg::slt;
                endcase
            end
            isa_pkg::op_jump: n_alu_op = pipe_pkg::pass_b;
            default: ;
        endcase
    end

    always_comb begin
        case (funct)
            isa_pkg::b_ne:  n_br_cond = pipe_pkg::ne;
            isa_pkg::b_lt:  n_br_cond = pipe_pkg::lt;
            isa_pkg::b_ge:  n_br_cond = pipe_pkg::ge;
            isa_pkg::b_ltu: n_br_cond = pipe_pkg::ltu;
            isa_pkg::b_geu: n_br_cond = pipe_pkg::geu;
            default:        n_br_cond = pipe_pkg::eq;
        endcase
    end

    // link address on both sides, pass_b takes op2
    assign n_op1 = is_link ? link_addr : rs1_val;

    always_comb begin
        case (op)
            isa_pkg::op_imm, isa_pkg::op_load: n_op2 = imm_i;
            isa_pkg::op_store:                 n_op2 = imm_s;
            isa_pkg::op_jump:                  n_op2 = link_addr;
            default:                           n_op2 = rs2_val;
        endcase
    end

    assign n_branch   = op == isa_pkg::op_branch && funct <= 3'(isa_pkg::b_geu);
    assign n_jump     = op == isa_pkg::op_jump && funct <= 3'(isa_pkg::j_reg);
    assign n_rd_valid = (op inside {isa_pkg::op_reg, isa_pkg::op_imm, isa_pkg::op_load} ||
                         is_link) && rd != '0;

    // load in execute feeding this instruction
    assign lw_hazard = dec_mem_re && dec_rd_valid &&
                       ((uses_rs1 && rs1 == dec_rd) || (uses_rs2 && rs2 == dec_rd));
    assign hold_n    = run & ~lw_hazard;   // low until the first edge out of reset
    assign bubble    = flush | ~hold_n;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run          <= 1'b0;
            dec_branch   <= 1'b0;
            dec_jump     <= 1'b0;
            dec_rd_valid <= 1'b0;
            dec_mem_re   <= 1'b0;
            dec_mem_we   <= 1'b0;
        end else begin
            run <= 1'b1;
            if (advance) begin
                dec_branch   <= n_branch & ~bubble;
                dec_jump     <= n_jump & ~bubble;
                dec_rd_valid <= n_rd_valid & ~bubble;
                dec_mem_re   <= (op == isa_pkg::op_load) & ~bubble;
                dec_mem_we   <= (op == isa_pkg::op_store) & ~bubble;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op1        <= n_op1;
            dec_op2        <= n_op2;
            dec_alu_op     <= n_alu_op;
            dec_br_cond    <= n_br_cond;
            dec_rd         <= rd;
            dec_store_data <= rs2_val;
            dec_daddr      <= n_daddr;
            dec_npc        <= n_tgt[pc_width-1:0];
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none

module execute_stage #(
    parameter int pc_width = 27
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       advance,
    input  logic [31:0]                dec_op1,
    input  logic [31:0]                dec_op2,
    input  pipe_pkg::alu_op_e          dec_alu_op,
    input  pipe_pkg::br_cond_e         dec_br_cond,
    input  logic                       dec_branch,
    input  logic                       dec_jump,
    input  logic [isa_pkg::reg_aw-1:0] dec_rd,
    input  logic                       dec_rd_valid,
    input  logic                       dec_mem_re,
    input  logic                       dec_mem_we,
    input  logic [31:0]                dec_store_data,
    input  logic [31:0]                dec_daddr,
    input  logic [pc_width-1:0]        dec_npc,
    input  logic [31:0]                mem_rdata,
    output logic [31:0]                alu_fwd,
    output logic [isa_pkg::reg_aw-1:0] ex_rd,
    output logic                       ex_fwd_ok,
    output logic                       redirect,
    output logic [pc_width-1:0]        target,
    output logic                       mem_re,
    output logic                       mem_we,
    output logic [31:0]                mem_addr,
    output logic [31:0]                mem_wdata,
    output logic                       wb_valid,
    output logic [isa_pkg::reg_aw-1:0] wb_rd,
    output logic [31:0]                wb_data
);

    logic [31:0]                alu_res;
    logic                       taken;
    logic                       wb_load;
    logic [31:0]                wb_res;

    always_comb begin
        case (dec_alu_op)
            pipe_pkg::sub:    alu_res = dec_op1 - dec_op2;
            pipe_pkg::and_:   alu_res = dec_op1 & dec_op2;
            pipe_pkg::or_:    alu_res = dec_op1 | dec_op2;
            pipe_pkg::xor_:   alu_res = dec_op1 ^ dec_op2;
            pipe_pkg::sll:    alu_res = dec_op1 << dec_op2[4:0];
            pipe_pkg::srl:    alu_res = dec_op1 >> dec_op2[4:0];
            pipe_pkg::slt:    alu_res = {31'd0, $signed(dec_op1) < $signed(dec_op2)};
            pipe_pkg::pass_b: alu_res = dec_op2;
            default:          alu_res = dec_op1 + dec_op2;
        endcase
    end

    always_comb begin
        case (dec_br_cond)
            pipe_pkg::ne:  taken = dec_op1 != dec_op2;
            pipe_pkg::lt:  taken = $signed(dec_op1) < $signed(dec_op2);
            pipe_pkg::ge:  taken = $signed(dec_op1) >= $signed(dec_op2);
            pipe_pkg::ltu: taken = dec_op1 < dec_op2;
            pipe_pkg::geu: taken = dec_op1 >= dec_op2;
            default:       taken = dec_op1 == dec_op2;
        endcase
    end

    assign redirect = (dec_branch & taken) | dec_jump;
    assign target   = dec_npc;   // computed in decode

    assign alu_fwd   = alu_res;
    assign ex_rd     = dec_rd;
    assign ex_fwd_ok = dec_rd_valid & ~dec_mem_re;   // load data not ready yet

    assign mem_re    = dec_mem_re;
    assign mem_we    = dec_mem_we;
    assign mem_addr  = dec_daddr;
    assign mem_wdata = dec_store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_load  <= 1'b0;
        end else if (advance) begin
            wb_valid <= dec_rd_valid;
            wb_load  <= dec_mem_re;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_rd  <= dec_rd;
            wb_res <= alu_res;
        end
    end

    // memory answers one cycle after the request
    assign wb_data = wb_load ? mem_rdata : wb_res;

endmodule

`default_nettype wire

// File: design/core_pipe_top.sv
`default_nettype none

module core_pipe_top #(
    parameter int pc_width = 27
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [31:0]                inst,
    input  logic [pc_width-1:0]        pc,
    input  logic                       advance,
    input  logic [31:0]                mem_rdata,
    output logic                       hold_n,
    output logic                       redirect,
    output logic [pc_width-1:0]        target,
    output logic                       mem_re,
    output logic                       mem_we,
    output logic [31:0]                mem_addr,
    output logic [31:0]                mem_wdata,
    output logic                       wb_valid,
    output logic [isa_pkg::reg_aw-1:0] wb_rd,
    output logic [31:0]                wb_data
);

    logic [31:0]                dec_op1, dec_op2;
    pipe_pkg::alu_op_e          dec_alu_op;
    pipe_pkg::br_cond_e         dec_br_cond;
    logic                       dec_branch, dec_jump;
    logic [isa_pkg::reg_aw-1:0] dec_rd;
    logic                       dec_rd_valid, dec_mem_re, dec_mem_we;
    logic [31:0]                dec_store_data, dec_daddr;
    logic [pc_width-1:0]        dec_npc;
    logic [31:0]                alu_fwd;
    logic [isa_pkg::reg_aw-1:0] ex_rd;
    logic                       ex_fwd_ok;

    decode_stage #(.pc_width(pc_width)) decode_i (
        .clk, .arst_n, .inst, .pc, .advance,
        .flush (redirect),   // squash the instruction behind a taken branch
        .alu_fwd, .ex_rd, .ex_fwd_ok,
        .wb_valid, .wb_rd, .wb_data,
        .hold_n,
        .dec_op1, .dec_op2, .dec_alu_op, .dec_br_cond,
        .dec_branch, .dec_jump, .dec_rd, .dec_rd_valid,
        .dec_mem_re, .dec_mem_we, .dec_store_data, .dec_daddr, .dec_npc
    );

    execute_stage #(.pc_width(pc_width)) execute_i (
        .clk, .arst_n, .advance,
        .dec_op1, .dec_op2, .dec_alu_op, .dec_br_cond,
        .dec_branch, .dec_jump, .dec_rd, .dec_rd_valid,
        .dec_mem_re, .dec_mem_we, .dec_store_data, .dec_daddr, .dec_npc,
        .mem_rdata,
        .alu_fwd, .ex_rd, .ex_fwd_ok,
        .redirect, .target,
        .mem_re, .mem_we, .mem_addr, .mem_wdata,
        .wb_valid, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // reset over the first 4 rising edges, released mid-cycle
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/core_pipe_assertions.sv
`default_nettype none

module core_pipe_assertions (
    input logic clk,
    input logic arst_n,
    input logic advance,
    input logic redirect,
    input logic mem_re,
    input logic mem_we,
    input logic wb_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // failed assertions so far

    // flush puts a bubble in decode, so a second redirect cannot follow
    redirect_single: assert property (
        @(posedge clk) disable iff (!arst_n) (redirect && advance) |=> !redirect
    ) else begin
        fail_count++;
        $error("redirect high on two advancing cycles in a row");
    end

    mem_strobe_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_re && mem_we)
    ) else begin
        fail_count++;
        $error("read and write strobes high together");
    end

    // first edge out of reset
    reset_quiet: assert property (
        @(posedge clk) $rose(arst_n) |-> !wb_valid && !mem_re && !mem_we && !redirect
    ) else begin
        fail_count++;
        $error("pipeline outputs active right after reset");
    end

endmodule

`default_nettype wire

// File: test/core_pipe_tb.sv
`default_nettype none

module core_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pc_width   = 27;
    localparam int prog_len   = 200;
    localparam int max_cycles = 20000;

    logic                       clk, arst_n;
    logic [31:0]                inst;
    logic [pc_width-1:0]        pc;
    logic                       advance;
    logic [31:0]                mem_rdata;
    logic                       hold_n, redirect, mem_re, mem_we, wb_valid;
    logic [pc_width-1:0]        target;
    logic [31:0]                mem_addr, mem_wdata, wb_data;
    logic [isa_pkg::reg_aw-1:0] wb_rd;

    // program kept as fields for the reference model
    isa_pkg::opcode_e           p_op [prog_len];
    logic [2:0]                 p_funct [prog_len];
    logic [isa_pkg::reg_aw-1:0] p_rs1 [prog_len];
    logic [isa_pkg::reg_aw-1:0] p_rs2 [prog_len];
    logic [isa_pkg::reg_aw-1:0] p_rd [prog_len];
    logic [15:0]                p_imm [prog_len];
    logic [31:0]                imem [prog_len];
    logic [31:0]                dmem [64];

    // expected results, program order
    logic [isa_pkg::reg_aw-1:0] exp_rd_q [$];
    logic [31:0]                exp_wb_q [$];
    logic [31:0]                exp_addr_q [$];
    logic [31:0]                exp_sdata_q [$];
    logic [31:0]                exp_laddr_q [$];
    logic [pc_width-1:0]        exp_tgt_q [$];
    int                         exp_holds;

    tb_clock_gen clock_i (.clk, .arst_n);

    core_pipe_top #(.pc_width(pc_width)) dut_i (
        .clk, .arst_n, .inst, .pc, .advance, .mem_rdata,
        .hold_n, .redirect, .target, .mem_re, .mem_we, .mem_addr, .mem_wdata,
        .wb_valid, .wb_rd, .wb_data
    );

    bind execute_stage core_pipe_assertions assert_i (
        .clk (clk), .arst_n (arst_n), .advance (advance), .redirect (redirect),
        .mem_re (mem_re), .mem_we (mem_we), .wb_valid (wb_valid)
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] fill_word(int idx);
        return 32'h9e37_79b9 * 32'(idx + 1);   // every index bit matters
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f, logic [31:0] a, logic [31:0] b);
        case (isa_pkg::alu_funct_e'(f))
            isa_pkg::f_add: return a + b;
            isa_pkg::f_sub: return a - b;
            isa_pkg::f_and: return a & b;
            isa_pkg::f_or:  return a | b;
            isa_pkg::f_xor: return a ^ b;
            isa_pkg::f_sll: return a << b[4:0];
            isa_pkg::f_srl: return a >> b[4:0];
            default:        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f, logic [31:0] a, logic [31:0] b);
        case (isa_pkg::br_funct_e'(f))
            isa_pkg::b_ne:  return a != b;
            isa_pkg::b_lt:  return $signed(a) < $signed(b);
            isa_pkg::b_ge:  return $signed(a) >= $signed(b);
            isa_pkg::b_ltu: return a < b;
            isa_pkg::b_geu: return a >= b;
            default:        return a == b;
        endcase
    endfunction

    function automatic logic reads_rs1(logic [7:0] w);
        return p_op[w] != isa_pkg::op_jump || p_funct[w] == isa_pkg::j_reg;
    endfunction

    function automatic logic reads_rs2(logic [7:0] w);
        return p_op[w] inside {isa_pkg::op_reg, isa_pkg::op_store, isa_pkg::op_branch};
    endfunction

    function automatic logic [31:0] encode_inst(logic [7:0] w);
        logic [31:0] word;
        word = '0;
        word[isa_pkg::opc_hi:isa_pkg::opc_lo]     = p_op[w];
        word[isa_pkg::funct_hi:isa_pkg::funct_lo] = p_funct[w];
        if (p_op[w] == isa_pkg::op_jump && p_funct[w] == isa_pkg::j_abs) begin
            word[isa_pkg::jt_hi:isa_pkg::jt_lo] = 26'(p_imm[w]);   // word address
        end else if (p_op[w] inside {isa_pkg::op_store, isa_pkg::op_branch}) begin
            word[isa_pkg::rs1_hi:isa_pkg::rs1_lo]   = p_rs1[w];
            word[isa_pkg::rs2_hi:isa_pkg::rs2_lo]   = p_rs2[w];
            word[isa_pkg::imm_s_hi:isa_pkg::imm_s_lo] = p_imm[w];
        end else begin
            word[isa_pkg::rs1_hi:isa_pkg::rs1_lo] = p_rs1[w];
            word[isa_pkg::rd_hi:isa_pkg::rd_lo]   = p_rd[w];
            if (p_op[w] == isa_pkg::op_reg) begin
                word[isa_pkg::rs2_hi:isa_pkg::rs2_lo] = p_rs2[w];
            end else begin
                word[isa_pkg::imm_i_hi:isa_pkg::imm_i_lo] = p_imm[w];
            end
        end
        return word;
    endfunction

    // dense hazards on r1..r7, only forward control flow
    task automatic build_program();
        logic [7:0]  w;
        int unsigned pick, k;
        for (int i = 0; i < prog_len; i++) begin
            w         = i[7:0];
            pick      = $urandom_range(0, 99);
            k         = $urandom_range(2, 6);
            p_funct[w] = 3'($urandom_range(0, 7));
            p_rs1[w]  = 5'($urandom_range(1, 7));
            p_rs2[w]  = 5'($urandom_range(1, 7));
            p_rd[w]   = 5'($urandom_range(1, 7));
            p_imm[w]  = 16'($urandom());
            if (pick < 45) begin
                p_op[w] = (pick < 22) ? isa_pkg::op_reg : isa_pkg::op_imm;
            end else if (pick < 60) begin
                p_op[w] = isa_pkg::op_load;
            end else if (pick < 72) begin
                p_op[w] = isa_pkg::op_store;
            end else if (pick < 88) begin
                p_op[w]    = isa_pkg::op_branch;
                p_funct[w] = 3'($urandom_range(0, 5));
                p_rs1[w]   = 5'($urandom_range(0, 7));
                p_rs2[w]   = 5'($urandom_range(0, 7));
                p_imm[w]   = 16'($urandom_range(1, 6));
            end else begin
                p_op[w]    = isa_pkg::op_jump;
                p_funct[w] = 3'($urandom_range(0, 2));
                p_rs1[w]   = '0;   // j_reg base is r0, target stays forward
                p_imm[w]   = (p_funct[w] == isa_pkg::j_link) ? 16'(k) : 16'(i + k);
            end
            imem[w] = encode_inst(w);
        end
    endtask

    task automatic run_model();
        logic [31:0]                m_reg [32];
        logic [31:0]                m_mem [64];
        logic [7:0]                 pcw;
        logic [31:0]                a, b, imm, res, addr, tgt;
        logic [isa_pkg::reg_aw-1:0] load_rd;
        logic                       wr;
        m_reg = '{default: 32'd0};
        for (int i = 0; i < 64; i++) begin
            m_mem[i[5:0]] = fill_word(i);
        end
        pcw       = '0;
        load_rd   = '0;
        exp_holds = 0;
        while (pcw < prog_len) begin
            a   = m_reg[p_rs1[pcw]];
            b   = m_reg[p_rs2[pcw]];
            imm = 32'($signed(p_imm[pcw]));
            tgt = 32'({pcw, 2'b00}) + 32'd4;
            wr  = 1'b0;
            res = '0;
            if (load_rd != '0 && ((reads_rs1(pcw) && p_rs1[pcw] == load_rd) ||
                                  (reads_rs2(pcw) && p_rs2[pcw] == load_rd))) begin
                exp_holds++;   // one bubble per load-use pair
            end
            load_rd = '0;
            case (p_op[pcw])
                isa_pkg::op_reg: begin
                    res = alu_ref(p_funct[pcw], a, b);
                    wr  = 1'b1;
                end
                isa_pkg::op_imm: begin
                    res = alu_ref(p_funct[pcw], a, imm);
                    wr  = 1'b1;
                end
                isa_pkg::op_load: begin
                    addr    = a + imm;
                    res     = m_mem[addr[7:2]];
                    wr      = 1'b1;
                    load_rd = p_rd[pcw];
                    exp_laddr_q.push_back(addr);
                end
                isa_pkg::op_store: begin
                    addr = a + imm;
                    m_mem[addr[7:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_sdata_q.push_back(b);
                end
                isa_pkg::op_branch: begin
                    if (branch_taken(p_funct[pcw], a, b)) begin
                        tgt = 32'({pcw, 2'b00}) + (imm << 2);
                        exp_tgt_q.push_back(tgt[pc_width-1:0]);
                    end
                end
                default: begin   // jumps
                    res = tgt;   // return address
                    case (p_funct[pcw])
                        isa_pkg::j_abs:  tgt = 32'({p_imm[pcw], 2'b00});
                        isa_pkg::j_link: tgt = 32'({pcw, 2'b00}) + (imm << 2);
                        default:         tgt = a + (imm << 2);
                    endcase
                    wr = p_funct[pcw] != isa_pkg::j_abs;
                    exp_tgt_q.push_back(tgt[pc_width-1:0]);
                end
            endcase
            if (wr && p_rd[pcw] != '0) begin
                m_reg[p_rd[pcw]] = res;
                exp_rd_q.push_back(p_rd[pcw]);
                exp_wb_q.push_back(res);
            end
            pcw = tgt[9:2];
        end
    endtask

    function automatic logic [31:0] fetch_word(logic [pc_width-1:0] addr);
        logic [pc_width-3:0] word;
        word = addr[pc_width-1:2];
        if (word < prog_len) begin
            return imem[word[7:0]];
        end
        return 32'd0;   // add r0, r0, r0 past the end
    endfunction

    task automatic check_wb(string name, logic [isa_pkg::reg_aw-1:0] rd, logic [31:0] data);
        logic [isa_pkg::reg_aw-1:0] exp_rd;
        logic [31:0]                exp_data;
        if (exp_rd_q.size() == 0) begin
            $display("writeback to r%0d that the program never makes", rd);
            abort_run();
        end else begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_wb_q.pop_front();
            if (rd !== exp_rd || data !== exp_data) begin
                $display("Error %s: expected r%0d = %h, actual r%0d = %h",
                         name, exp_rd, exp_data, rd, data);
                abort_run();
            end
        end
    endtask

    task automatic check_store(string name, logic [31:0] addr, logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        if (exp_addr_q.size() == 0) begin
            $display("store to %h that the program never makes", addr);
            abort_run();
        end else begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_sdata_q.pop_front();
            if (addr !== exp_addr || data !== exp_data) begin
                $display("Error %s: expected [%h] = %h, actual [%h] = %h",
                         name, exp_addr, exp_data, addr, data);
                abort_run();
            end
        end
    endtask

    task automatic check_load(string name, logic [31:0] addr);
        logic [31:0] exp_addr;
        if (exp_laddr_q.size() == 0) begin
            $display("load from %h that the program never makes", addr);
            abort_run();
        end else begin
            exp_addr = exp_laddr_q.pop_front();
            if (addr !== exp_addr) begin
                $display("Error %s: expected address %h, actual address %h",
                         name, exp_addr, addr);
                abort_run();
            end
        end
    endtask

    task automatic check_redirect(string name, logic [pc_width-1:0] tgt);
        logic [pc_width-1:0] exp_tgt;
        if (exp_tgt_q.size() == 0) begin
            $display("redirect to %h that the program never takes", tgt);
            abort_run();
        end else begin
            exp_tgt = exp_tgt_q.pop_front();
            if (tgt !== exp_tgt) begin
                $display("Error %s: expected target %h, actual target %h", name, exp_tgt, tgt);
                abort_run();
            end
        end
    endtask

    function automatic logic results_pending();
        return exp_rd_q.size() != 0 || exp_addr_q.size() != 0 ||
               exp_laddr_q.size() != 0 || exp_tgt_q.size() != 0;
    endfunction

    initial begin
        int                  cycles;
        int                  drain;
        int                  holds;
        logic [pc_width-1:0] pc_q;
        logic [31:0]         rdata_q;
        void'($urandom(32'h9150));
        inst      = '0;
        pc        = '0;
        advance   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = fill_word(i);
        end
        build_program();
        run_model();

        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("reset was never released");
                abort_run();
            end
        end

        // fetch and data memory, one cycle per pass
        pc_q    = '0;
        rdata_q = '0;
        holds   = 0;
        cycles  = 0;
        drain   = 0;
        while (results_pending() || drain < 10) begin
            @(negedge clk);
            advance   = $urandom_range(0, 9) != 0;   // stalls about 10% of cycles
            pc        = pc_q;
            inst      = fetch_word(pc_q);
            mem_rdata = rdata_q;
            #1;
            if (advance) begin
                if (!hold_n) begin
                    holds++;
                end
                if (wb_valid) begin
                    check_wb("alu_wb", wb_rd, wb_data);
                end
                if (mem_we) begin
                    check_store("store", mem_addr, mem_wdata);
                    dmem[mem_addr[7:2]] = mem_wdata;
                end
                if (mem_re) begin
                    check_load("load", mem_addr);
                    rdata_q = dmem[mem_addr[7:2]];   // seen by the load next cycle
                end
                if (redirect) begin
                    check_redirect("branch_jump", target);
                    pc_q = target;
                end else if (hold_n) begin
                    pc_q = pc_q + pc_width'(4);
                end
            end
            if (!results_pending()) begin
                drain++;
            end
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout, the pipeline did not finish the program");
                abort_run();
            end
        end

        if (dut_i.execute_i.assert_i.fail_count != 0) begin
            $display("a bound assertion on the pipeline control signals failed");
            abort_run();
        end else if (results_pending()) begin
            $display("results still expected at the end of the run");
            abort_run();
        end else if (holds != exp_holds) begin
            $display("Error load_use: expected %0d hold cycles, actual %0d", exp_holds, holds);
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_pipe_top.sv
test/tb_clock_gen.sv
test/core_pipe_assertions.sv
test/core_pipe_tb.sv

// File: Makefile
TOP = core_pipe_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
